// ==== compute_tile.f ====
src/tile_pkg.sv
src/core_regfile.sv
src/mini_cpu.sv
src/cpu_module.sv
src/tile_ram.sv
src/compute_tile.sv
tests/tb_compute_tile.sv

// ==== Makefile ====
TOP := tb_compute_tile

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f compute_tile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compute_tile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== tests/tb_compute_tile.sv ====
`timescale 1ns/1ps
// Testbench of the compute tile that loads one program under reset and checks the retire trace
// Then halts the core, checks debug reads and writes and resumes it
module tb_compute_tile import tile_pkg::*; ();

   localparam int TIMEOUT = 200;   // Cycles per wait

   typedef struct packed {
      logic [DATA_W-1:0] pc;
      logic              wben;
      logic [REG_AW-1:0] wbreg;
      logic [DATA_W-1:0] wbdata;
   } retire_row_t;

   logic              clk_i;
   logic              rst_i;
   logic              dbg_stall_i;
   logic              dbg_stb_i;
   logic              dbg_we_i;
   logic [DATA_W-1:0] dbg_adr_i;
   logic [DATA_W-1:0] dbg_dat_i;
   logic              dbg_ack_o;
   logic              dbg_halted_o;
   logic [DATA_W-1:0] dbg_dat_o;
   logic              ld_we_i;
   logic [DATA_W-1:0] ld_adr_i;
   logic [DATA_W-1:0] ld_dat_i;
   trace_exec_t       trace_o;

   logic [DATA_W-1:0] prog [$];      // Program words from address 0
   retire_row_t       expect_q [$];  // Expected retire records
   logic [DATA_W-1:0] halt_regs [8]; // Register values once halted

   compute_tile #(
      .CORE_ID   (3),
      .NUM_CORES (4),
      .RAM_WORDS (256)
   ) i_compute_tile (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .dbg_stall_i  (dbg_stall_i),
      .dbg_stb_i    (dbg_stb_i),
      .dbg_we_i     (dbg_we_i),
      .dbg_adr_i    (dbg_adr_i),
      .dbg_dat_i    (dbg_dat_i),
      .dbg_ack_o    (dbg_ack_o),
      .dbg_halted_o (dbg_halted_o),
      .dbg_dat_o    (dbg_dat_o),
      .ld_we_i      (ld_we_i),
      .ld_adr_i     (ld_adr_i),
      .ld_dat_i     (ld_dat_i),
      .trace_o      (trace_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;   // 100 ns period
   end

   // Field layout op, rd, ra, rb, reserved, imm
   function automatic logic [DATA_W-1:0] insn_word(input logic [3:0] op, input int rd,
                                                    input int ra, input int rb,
                                                    input logic [15:0] imm);
      return {op, rd[2:0], ra[2:0], rb[2:0], 3'b000, imm};
   endfunction

   task automatic add_row(input int pc, input logic wben, input int wbreg, input int wbdata);
      expect_q.push_back('{pc: pc, wben: wben, wbreg: wbreg[2:0], wbdata: wbdata});
   endtask

   task automatic abort_run();
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped after a failed check");
   endtask

   // Advance to 1 ns after the next rising edge
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic check_idle_outputs();
      assert (!trace_o.valid && !dbg_ack_o && !dbg_halted_o) else begin
         $display("ERROR %0t: control outputs not low (valid %b ack %b halted %b)",
                  $time, trace_o.valid, dbg_ack_o, dbg_halted_o);
         abort_run();
      end
   endtask

   task automatic wait_retire();
      int n;
      n = 0;
      while (!trace_o.valid) begin
         if (n == TIMEOUT) begin
            $display("Timed out waiting for an instruction to retire");
            abort_run();
         end
         next_cycle();
         n++;
      end
   endtask

   task automatic wait_halted();
      int n;
      n = 0;
      while (!dbg_halted_o) begin
         if (n == TIMEOUT) begin
            $display("Timed out waiting for the core to halt");
            abort_run();
         end
         next_cycle();
         n++;
      end
   endtask

   task automatic check_retire(input retire_row_t row);
      wait_retire();
      assert (trace_o.pc == row.pc && trace_o.wben == row.wben &&
              (!row.wben || (trace_o.wbreg == row.wbreg && trace_o.wbdata == row.wbdata)))
      else begin
         $display("ERROR %0t: retire pc %h wben %b r%0d=%h, expected pc %h wben %b r%0d=%h",
                  $time, trace_o.pc, trace_o.wben, trace_o.wbreg, trace_o.wbdata,
                  row.pc, row.wben, row.wbreg, row.wbdata);
         abort_run();
      end
      assert (trace_o.insn == prog[row.pc / 4]) else begin   // Word loaded at that PC
         $display("ERROR %0t: retire at pc %h shows insn %h, expected %h",
                  $time, trace_o.pc, trace_o.insn, prog[row.pc / 4]);
         abort_run();
      end
      next_cycle();   // Leave the retire cycle
   endtask

   // Single strobe whose ack must follow exactly one cycle later
   task automatic dbg_access(input logic we, input int adr, input logic [DATA_W-1:0] dat,
                             output logic [DATA_W-1:0] rdata);
      dbg_stb_i = 1'b1;
      dbg_we_i  = we;
      dbg_adr_i = adr;
      dbg_dat_i = dat;
      assert (!dbg_ack_o) else begin
         $display("ERROR %0t: debug ack high in the strobe cycle", $time);
         abort_run();
      end
      next_cycle();
      dbg_stb_i = 1'b0;
      dbg_we_i  = 1'b0;
      assert (dbg_ack_o) else begin
         $display("ERROR %0t: no debug ack one cycle after strobe, adr %0d", $time, adr);
         abort_run();
      end
      rdata = dbg_dat_o;
      next_cycle();
      assert (!dbg_ack_o) else begin
         $display("ERROR %0t: debug ack lasted more than one cycle", $time);
         abort_run();
      end
   endtask

   task automatic check_dbg_read(input int adr, input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] rdata;
      dbg_access(1'b0, adr, '0, rdata);
      assert (rdata == exp) else begin
         $display("ERROR %0t: debug read adr %0d got %h, expected %h", $time, adr, rdata, exp);
         abort_run();
      end
   endtask

   initial begin
      logic [DATA_W-1:0] dummy;
      int                idle;
      void'($urandom(32'hc32344b3));
      rst_i       = 1'b1;
      dbg_stall_i = 1'b0;
      dbg_stb_i   = 1'b0;
      dbg_we_i    = 1'b0;
      dbg_adr_i   = '0;
      dbg_dat_i   = '0;
      ld_we_i     = 1'b0;
      ld_adr_i    = '0;
      ld_dat_i    = '0;

      prog = {insn_word(OP_ADDI, 1, 0, 0, 16'd5),         // 0   r1 = 5
              insn_word(OP_ADDI, 2, 0, 0, 16'd12),        // 4   r2 = 12
              insn_word(OP_ADD,  3, 1, 2, 16'd0),         // 8
              insn_word(OP_SUB,  4, 2, 1, 16'd0),         // 12
              insn_word(OP_AND,  5, 1, 2, 16'd0),         // 16
              insn_word(OP_OR,   6, 1, 2, 16'd0),         // 20
              insn_word(OP_XOR,  7, 1, 2, 16'd0),         // 24
              insn_word(OP_ADDI, 0, 1, 0, 16'd3),         // 28  Write to r0
              insn_word(OP_ADD,  3, 0, 1, 16'd0),         // 32  r0 must still read 0
              32'hF000_0000,                              // 36  Undefined opcode
              insn_word(OP_ADDI, 6, 0, 0, 16'h0100),      // 40  Data base
              insn_word(OP_SW,   0, 6, 4, 16'd4),         // 44  mem[260] = r4
              insn_word(OP_LW,   5, 6, 0, 16'd4),         // 48
              insn_word(OP_ADDI, 1, 0, 0, 16'd3),         // 52  Loop count
              insn_word(OP_ADDI, 1, 1, 0, 16'hFFFF),      // 56  r1--
              insn_word(OP_BNE,  0, 1, 0, 16'hFFFE),      // 60  Back to 56
              insn_word(OP_COREID, 2, 0, 0, 16'd0),       // 64
              insn_word(OP_BNE,  0, 7, 0, 16'hFFFF),      // 68  Spin here
              insn_word(OP_ADD,  3, 1, 4, 16'd0),         // 72  Reached by debug PC write
              insn_word(OP_BNE,  0, 7, 0, 16'hFFFF)};     // 76

      add_row(0,  1'b1, 1, 5);
      add_row(4,  1'b1, 2, 12);
      add_row(8,  1'b1, 3, 17);
      add_row(12, 1'b1, 4, 7);
      add_row(16, 1'b1, 5, 4);
      add_row(20, 1'b1, 6, 13);
      add_row(24, 1'b1, 7, 9);
      add_row(28, 1'b1, 0, 8);
      add_row(32, 1'b1, 3, 5);
      add_row(36, 1'b0, 0, 0);
      add_row(40, 1'b1, 6, 256);
      add_row(44, 1'b0, 0, 0);
      add_row(48, 1'b1, 5, 7);
      add_row(52, 1'b1, 1, 3);
      add_row(56, 1'b1, 1, 2);
      add_row(60, 1'b0, 0, 0);
      add_row(56, 1'b1, 1, 1);
      add_row(60, 1'b0, 0, 0);
      add_row(56, 1'b1, 1, 0);
      add_row(60, 1'b0, 0, 0);   // Falls through
      add_row(64, 1'b1, 2, 32'h0004_0003);
      add_row(68, 1'b0, 0, 0);

      halt_regs = '{32'd0, 32'd0, 32'h0004_0003, 32'd5, 32'd7, 32'd7, 32'h100, 32'd9};

      next_cycle();
      foreach (prog[i]) begin   // Load runs under reset
         ld_we_i  = 1'b1;
         ld_adr_i = i * 4;
         ld_dat_i = prog[i];
         next_cycle();
         check_idle_outputs();
      end
      ld_we_i = 1'b0;
      repeat (10) begin
         next_cycle();
         check_idle_outputs();
      end
      rst_i = 1'b0;
      next_cycle();
      check_idle_outputs();   // First cycle out of reset

      foreach (expect_q[i]) check_retire(expect_q[i]);

      check_dbg_read(7, 32'd0);   // Core still running so r7 reads as zero
      idle = $urandom % 8 + 1;
      repeat (idle) next_cycle();
      dbg_stall_i = 1'b1;
      wait_halted();

      for (int r = 0; r < 8; r++) check_dbg_read(r, halt_regs[r]);
      check_dbg_read(8, 32'd68);
      check_dbg_read(9, 32'h0004_0003);

      dbg_access(1'b1, 1, 32'h1000, dummy);
      dbg_access(1'b1, 8, 32'd72, dummy);   // Jump to the ADD
      check_dbg_read(1, 32'h1000);
      check_dbg_read(8, 32'd72);

      dbg_stall_i = 1'b0;
      next_cycle();
      check_retire('{pc: 72, wben: 1'b1, wbreg: 3'd3, wbdata: 32'h1007});

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== src/compute_tile.sv ====
`timescale 1ns/1ps
// Compute tile top level joining one core wrapper to its local memory
module compute_tile import tile_pkg::*; #(
   parameter int CORE_ID   = 0,
   parameter int NUM_CORES = 1,
   parameter int RAM_WORDS = 256
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              dbg_stall_i,
   input  logic              dbg_stb_i,
   input  logic              dbg_we_i,
   input  logic [DATA_W-1:0] dbg_adr_i,
   input  logic [DATA_W-1:0] dbg_dat_i,
   output logic              dbg_ack_o,
   output logic              dbg_halted_o,
   output logic [DATA_W-1:0] dbg_dat_o,
   input  logic              ld_we_i,      // Program load, reset only
   input  logic [DATA_W-1:0] ld_adr_i,
   input  logic [DATA_W-1:0] ld_dat_i,
   output trace_exec_t       trace_o
);

   bus_req_t ibus_req;
   bus_rsp_t ibus_rsp;
   bus_req_t dbus_req;
   bus_rsp_t dbus_rsp;

   cpu_module #(
      .CORE_ID   (CORE_ID),
      .NUM_CORES (NUM_CORES)
   ) u_cpu_module (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .dbg_stall_i  (dbg_stall_i),
      .dbg_stb_i    (dbg_stb_i),
      .dbg_we_i     (dbg_we_i),
      .dbg_adr_i    (dbg_adr_i),
      .dbg_dat_i    (dbg_dat_i),
      .dbg_ack_o    (dbg_ack_o),
      .dbg_dat_o    (dbg_dat_o),
      .dbg_halted_o (dbg_halted_o),
      .ibus_req_o   (ibus_req),
      .ibus_rsp_i   (ibus_rsp),
      .dbus_req_o   (dbus_req),
      .dbus_rsp_i   (dbus_rsp),
      .trace_o      (trace_o)
   );

   tile_ram #(
      .RAM_WORDS (RAM_WORDS)
   ) u_ram (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ibus_req_i (ibus_req),
      .dbus_req_i (dbus_req),
      .ibus_rsp_o (ibus_rsp),
      .dbus_rsp_o (dbus_rsp),
      .ld_we_i    (ld_we_i),
      .ld_adr_i   (ld_adr_i),
      .ld_dat_i   (ld_dat_i)
   );

endmodule

// ==== src/tile_ram.sv ====
`timescale 1ns/1ps
// Word memory of the tile serving the instruction and data buses
// Program is written through the load port while the tile is in reset
module tile_ram import tile_pkg::*; #(
   parameter int RAM_WORDS = 256
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  bus_req_t          ibus_req_i,
   input  bus_req_t          dbus_req_i,
   output bus_rsp_t          ibus_rsp_o,
   output bus_rsp_t          dbus_rsp_o,
   input  logic              ld_we_i,
   input  logic [DATA_W-1:0] ld_adr_i,
   input  logic [DATA_W-1:0] ld_dat_i
);

   localparam int AW = $clog2(RAM_WORDS);

   logic [DATA_W-1:0] mem_q [RAM_WORDS];
   bus_rsp_t          ibus_q;
   bus_rsp_t          dbus_q;
   logic              i_go;       // First cycle of a request
   logic              d_go;

   // Drop byte offset, wrap at RAM_WORDS
   function automatic logic [AW-1:0] word_idx(input logic [DATA_W-1:0] adr);
      return AW'(adr[DATA_W-1:2] % RAM_WORDS);
   endfunction

   assign i_go = ibus_req_i.cyc && !ibus_q.ack;
   assign d_go = dbus_req_i.cyc && !dbus_q.ack;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ibus_q.ack <= 1'b0;
         dbus_q.ack <= 1'b0;
      end else begin
         ibus_q.ack <= i_go;
         dbus_q.ack <= d_go;
      end
      if (ld_we_i) begin
         mem_q[word_idx(ld_adr_i)] <= ld_dat_i;
      end else if (d_go && dbus_req_i.we) begin   // Visible from the ack cycle
         mem_q[word_idx(dbus_req_i.adr)] <= dbus_req_i.dat;
      end
      if (i_go) ibus_q.dat <= mem_q[word_idx(ibus_req_i.adr)];
      if (d_go) dbus_q.dat <= mem_q[word_idx(dbus_req_i.adr)];
   end

   assign ibus_rsp_o = ibus_q;
   assign dbus_rsp_o = dbus_q;

   // Requester holds cyc through the ack cycle
   a_iack_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      ibus_q.ack |-> ibus_req_i.cyc);
   a_dack_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      dbus_q.ack |-> dbus_req_i.cyc);

endmodule

// ==== src/cpu_module.sv ====
`timescale 1ns/1ps
// Processor wrapper with the debug unit, core number settings and trace output
// Debug accesses reach the core only while it sits halted
module cpu_module import tile_pkg::*; #(
   parameter int CORE_ID   = 0,
   parameter int NUM_CORES = 1
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              dbg_stall_i,
   input  logic              dbg_stb_i,    // One-cycle strobe
   input  logic              dbg_we_i,
   input  logic [DATA_W-1:0] dbg_adr_i,
   input  logic [DATA_W-1:0] dbg_dat_i,
   output logic              dbg_ack_o,    // Strobe plus one cycle
   output logic [DATA_W-1:0] dbg_dat_o,
   output logic              dbg_halted_o,
   output bus_req_t          ibus_req_o,
   input  bus_rsp_t          ibus_rsp_i,
   output bus_req_t          dbus_req_o,
   input  bus_rsp_t          dbus_rsp_i,
   output trace_exec_t       trace_o
);

   logic              halted;
   logic              hit_core;   // GPR or PC address
   logic              ra_we;
   logic [DATA_W-1:0] ra_rdat;
   logic [DATA_W-1:0] rd_data;

   assign hit_core = dbg_adr_i <= DATA_W'(8);
   assign ra_we    = dbg_stb_i && dbg_we_i && halted && hit_core;   // Dropped if running

   // Read mux gives zero while the core runs
   always_comb begin
      rd_data = '0;
      if (halted && !dbg_we_i) begin
         if (hit_core) begin
            rd_data = ra_rdat;
         end else if (dbg_adr_i == DATA_W'(9)) begin
            rd_data = core_word(CORE_ID, NUM_CORES);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dbg_ack_o <= 1'b0;
      end else begin
         dbg_ack_o <= dbg_stb_i;
      end
      if (dbg_stb_i) begin
         dbg_dat_o <= rd_data;
      end
   end

   assign dbg_halted_o = halted;

   mini_cpu #(
      .CORE_ID   (CORE_ID),
      .NUM_CORES (NUM_CORES)
   ) u_cpu (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .stall_i    (dbg_stall_i),
      .halted_o   (halted),
      .ra_we_i    (ra_we),
      .ra_adr_i   (dbg_adr_i[3:0]),
      .ra_dat_i   (dbg_dat_i),
      .ra_dat_o   (ra_rdat),
      .ibus_req_o (ibus_req_o),
      .ibus_rsp_i (ibus_rsp_i),
      .dbus_req_o (dbus_req_o),
      .dbus_rsp_i (dbus_rsp_i),
      .trace_o    (trace_o)
   );

   // Strobe is a single-cycle pulse
   a_dbg_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      dbg_stb_i |=> !dbg_stb_i);

endmodule

// ==== src/mini_cpu.sv ====
`timescale 1ns/1ps
// Multi-cycle core with fetch, execute and memory states and a retire trace
// Stalls into S_HALT, where the register access port reads or writes state
module mini_cpu import tile_pkg::*; #(
   parameter int CORE_ID   = 0,
   parameter int NUM_CORES = 1
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              stall_i,    // Halt after current insn
   output logic              halted_o,
   input  logic              ra_we_i,    // Honoured in S_HALT only
   input  logic [3:0]        ra_adr_i,   // 0..7 GPR, 8 PC
   input  logic [DATA_W-1:0] ra_dat_i,
   output logic [DATA_W-1:0] ra_dat_o,
   output bus_req_t          ibus_req_o,
   input  bus_rsp_t          ibus_rsp_i,
   output bus_req_t          dbus_req_o,
   input  bus_rsp_t          dbus_rsp_i,
   output trace_exec_t       trace_o
);

   cpu_state_e        state_q;
   logic [DATA_W-1:0] pc_q;       // Byte PC of current insn
   insn_t             insn_q;
   bus_req_t          ibus_q;
   bus_req_t          dbus_q;
   trace_exec_t       trace_q;

   logic [REG_AW-1:0] rf_rd_a;
   logic [REG_AW-1:0] rf_rd_b;
   logic [REG_AW-1:0] rf_wr;
   logic [DATA_W-1:0] rf_wd;
   logic              rf_we;
   logic [DATA_W-1:0] opa;
   logic [DATA_W-1:0] opb;
   logic [DATA_W-1:0] simm;
   logic [DATA_W-1:0] alu_res;
   logic              alu_wb;
   logic              is_mem;
   logic              halted;
   logic              retire;
   logic              wb_en;
   logic [DATA_W-1:0] wb_data;
   logic [DATA_W-1:0] pc_inc;
   logic [DATA_W-1:0] pc_nxt;
   logic              boundary;   // Between instructions
   logic [DATA_W-1:0] fetch_adr;

   assign halted = state_q == S_HALT;
   assign simm   = {{(DATA_W-16){insn_q.imm[15]}}, insn_q.imm};
   assign is_mem = insn_q.op inside {OP_LW, OP_SW};
   assign pc_inc = pc_q + DATA_W'(4);
   // Branch offset counts words from the next PC
   assign pc_nxt = (insn_q.op == OP_BNE && opa != opb) ? pc_inc + (simm << 2) : pc_inc;

   // Port A doubles as the debug read port while halted
   assign rf_rd_a = halted ? ra_adr_i[REG_AW-1:0] : insn_q.ra;
   assign rf_rd_b = (insn_q.op == OP_BNE) ? insn_q.rd : insn_q.rb;   // BNE compares rd

   always_comb begin
      alu_wb  = 1'b1;
      alu_res = '0;
      case (insn_q.op)
         OP_ADDI:   alu_res = opa + simm;
         OP_ADD:    alu_res = opa + opb;
         OP_SUB:    alu_res = opa - opb;
         OP_AND:    alu_res = opa & opb;
         OP_OR:     alu_res = opa | opb;
         OP_XOR:    alu_res = opa ^ opb;
         OP_COREID: alu_res = core_word(CORE_ID, NUM_CORES);
         default:   alu_wb  = 1'b0;   // NOP, BNE, LW/SW, undefined codes
      endcase
   end

   // Retire in EXEC for ALU ops, on data ack for memory ops
   assign retire  = (state_q == S_EXEC && !is_mem) || (state_q == S_MEM && dbus_rsp_i.ack);
   assign wb_en   = (state_q == S_MEM) ? insn_q.op == OP_LW : alu_wb;
   assign wb_data = (state_q == S_MEM) ? dbus_rsp_i.dat : alu_res;

   // Write port shared with debug access
   assign rf_we = halted ? (ra_we_i && !ra_adr_i[3]) : (retire && wb_en);
   assign rf_wr = halted ? ra_adr_i[REG_AW-1:0] : insn_q.rd;
   assign rf_wd = halted ? ra_dat_i : wb_data;

   assign boundary  = retire || halted || (state_q == S_FETCH && !ibus_q.cyc);
   assign fetch_adr = retire ? pc_nxt : pc_q;

   core_regfile u_regfile (
      .clk_i  (clk_i),
      .rd_a_i (rf_rd_a),
      .rd_b_i (rf_rd_b),
      .rd_a_o (opa),
      .rd_b_o (opb),
      .we_i   (rf_we),
      .wr_i   (rf_wr),
      .wd_i   (rf_wd)
   );

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q       <= S_FETCH;
         pc_q          <= '0;
         ibus_q.cyc    <= 1'b0;
         dbus_q.cyc    <= 1'b0;
         trace_q.valid <= 1'b0;
      end else begin
         trace_q.valid <= 1'b0;   // Single-cycle pulse
         case (state_q)
            S_FETCH: begin
               if (ibus_q.cyc && ibus_rsp_i.ack) begin
                  ibus_q.cyc <= 1'b0;
                  insn_q     <= insn_t'(ibus_rsp_i.dat);
                  state_q    <= S_EXEC;
               end
            end
            S_EXEC: begin
               if (is_mem) begin   // Address is ra + simm
                  dbus_q  <= '{cyc: 1'b1, we: insn_q.op == OP_SW, adr: opa + simm, dat: opb};
                  state_q <= S_MEM;
               end
            end
            S_MEM: begin
               if (dbus_rsp_i.ack) begin
                  dbus_q.cyc <= 1'b0;
               end
            end
            S_HALT: begin
               if (ra_we_i && ra_adr_i[3]) begin   // Debug PC write
                  pc_q <= ra_dat_i;
               end
            end
            default: state_q <= S_FETCH;
         endcase

         if (retire) begin
            trace_q <= '{valid: 1'b1, pc: pc_q, insn: insn_q, wben: wb_en,
                         wbreg: insn_q.rd, wbdata: wb_data};
            pc_q    <= pc_nxt;
         end

         // Stall is sampled only between instructions
         if (boundary) begin
            state_q <= stall_i ? S_HALT : S_FETCH;
            if (!stall_i) begin
               ibus_q <= '{cyc: 1'b1, we: 1'b0, adr: fetch_adr, dat: '0};
            end
         end
      end
   end

   assign halted_o   = halted;
   assign ra_dat_o   = ra_adr_i[3] ? pc_q : opa;
   assign ibus_req_o = ibus_q;
   assign dbus_req_o = dbus_q;
   assign trace_o    = trace_q;

   // Requests must not move while waiting on the memory
   a_ibus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      ibus_q.cyc && !ibus_rsp_i.ack |=> $stable(ibus_q));
   a_dbus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      dbus_q.cyc && !dbus_rsp_i.ack |=> $stable(dbus_q));

endmodule

// ==== src/core_regfile.sv ====
`timescale 1ns/1ps
// Register file of the core with two combinational reads and one write
module core_regfile import tile_pkg::*; (
   input  logic              clk_i,
   input  logic [REG_AW-1:0] rd_a_i,
   input  logic [REG_AW-1:0] rd_b_i,
   output logic [DATA_W-1:0] rd_a_o,
   output logic [DATA_W-1:0] rd_b_o,
   input  logic              we_i,
   input  logic [REG_AW-1:0] wr_i,
   input  logic [DATA_W-1:0] wd_i
);

   logic [DATA_W-1:0] regs_q [2**REG_AW];   // Entry zero never written

   always_ff @(posedge clk_i) begin
      if (we_i && wr_i != '0) begin   // r0 drops writes
         regs_q[wr_i] <= wd_i;
      end
   end

   // r0 is hardwired to zero
   assign rd_a_o = (rd_a_i == '0) ? '0 : regs_q[rd_a_i];
   assign rd_b_o = (rd_b_i == '0) ? '0 : regs_q[rd_b_i];

endmodule

// ==== src/tile_pkg.sv ====
// Shared widths, opcode and state encodings, bus and trace structs of the tile
// Imported by every tile module through a wildcard import in the module header
package tile_pkg;

   localparam int DATA_W = 32;   // Data and address width
   localparam int REG_AW = 3;    // Eight registers

   // Opcode in instruction bits 31..28
   typedef enum logic [3:0] {
      OP_NOP    = 4'd0,
      OP_ADDI   = 4'd1,
      OP_ADD    = 4'd2,
      OP_SUB    = 4'd3,
      OP_AND    = 4'd4,
      OP_OR     = 4'd5,
      OP_XOR    = 4'd6,
      OP_LW     = 4'd7,
      OP_SW     = 4'd8,
      OP_BNE    = 4'd9,
      OP_COREID = 4'd10
   } op_e;

   typedef enum logic [1:0] {
      S_FETCH,
      S_EXEC,
      S_MEM,
      S_HALT
   } cpu_state_e;

   // Instruction word layout
   typedef struct packed {
      op_e               op;     // 31..28
      logic [REG_AW-1:0] rd;     // 27..25 destination and BNE compare
      logic [REG_AW-1:0] ra;     // 24..22
      logic [REG_AW-1:0] rb;     // 21..19
      logic [2:0]        rsvd;   // 18..16
      logic [15:0]       imm;    // Sign extended on use
   } insn_t;

   typedef struct packed {
      logic              cyc;    // Held until ack
      logic              we;
      logic [DATA_W-1:0] adr;    // Byte address, word aligned
      logic [DATA_W-1:0] dat;
   } bus_req_t;

   typedef struct packed {
      logic              ack;    // One cycle
      logic [DATA_W-1:0] dat;
   } bus_rsp_t;

   typedef struct packed {
      logic              valid;  // Retire pulse
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] insn;
      logic              wben;
      logic [REG_AW-1:0] wbreg;
      logic [DATA_W-1:0] wbdata;
   } trace_exec_t;

   // Core count in the upper half, core number in the lower half
   function automatic logic [DATA_W-1:0] core_word(input int core_id, input int num_cores);
      return {num_cores[15:0], core_id[15:0]};
   endfunction

endpackage
